// File: rtl/nnPkg.sv
package nnPkg;

	typedef logic signed [7:0] act_t; // 6 fraction bits
	typedef logic signed [7:0] weight_t; // same scale as act_t
	typedef logic signed [15:0] product_t;
	typedef logic signed [15:0] bias_t; // product scale, 12 fraction bits
	typedef logic signed [22:0] accum_t;
	typedef logic [7:0] axiAddr_t;
	typedef logic [31:0] axiData_t;

	localparam int L1_IN = 15;
	localparam int L1_OUT = 8;
	localparam int L2_OUT = 4;

	// input register, accumulator register, output register
	localparam int LAYER_LATENCY = 3;

	localparam axiAddr_t ADDR_IN_BASE = 8'h00; // 0x00 .. 0x38
	localparam axiAddr_t ADDR_CTRL = 8'h40; // bit 0 starts an inference
	localparam axiAddr_t ADDR_STATUS = 8'h44; // bit 0 done, bit 1 busy
	localparam axiAddr_t ADDR_RES_BASE = 8'h80; // 0x80 .. 0x8C

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// entry [n*L1_IN + i] is the weight of input i into neuron n
	localparam weight_t [0:L1_OUT*L1_IN-1] L1_WEIGHTS = {
		8'sd23, -8'sd41, 8'sd7, 8'sd56, -8'sd12, 8'sd33, -8'sd5, 8'sd18, // neuron 0
		-8'sd47, 8'sd29, 8'sd11, -8'sd38, 8'sd4, 8'sd52, -8'sd19,
		-8'sd31, 8'sd14, 8'sd45, -8'sd8, 8'sd27, -8'sd53, 8'sd36, 8'sd2, // neuron 1
		8'sd19, -8'sd24, 8'sd61, -8'sd15, 8'sd9, -8'sd44, 8'sd30,
		8'sd48, 8'sd6, -8'sd27, 8'sd39, -8'sd58, 8'sd13, -8'sd3, 8'sd25, // neuron 2
		8'sd35, -8'sd11, -8'sd42, 8'sd57, 8'sd21, -8'sd7, -8'sd34,
		-8'sd9, 8'sd50, 8'sd17, -8'sd36, 8'sd3, 8'sd44, -8'sd26, 8'sd59, // neuron 3
		-8'sd13, 8'sd40, -8'sd49, 8'sd8, 8'sd31, 8'sd22, -8'sd55,
		8'sd12, -8'sd33, -8'sd60, 8'sd26, 8'sd41, -8'sd17, 8'sd54, -8'sd2, // neuron 4
		8'sd28, -8'sd46, 8'sd15, 8'sd37, -8'sd21, 8'sd5, 8'sd43,
		8'sd62, 8'sd20, -8'sd15, -8'sd45, 8'sd10, 8'sd31, -8'sd39, 8'sd47, // neuron 5
		-8'sd6, 8'sd16, 8'sd27, -8'sd52, 8'sd38, -8'sd30, 8'sd1,
		-8'sd22, -8'sd57, 8'sd34, 8'sd9, -8'sd40, 8'sd58, 8'sd24, -8'sd18, // neuron 6
		8'sd49, 8'sd3, -8'sd35, 8'sd14, -8'sd63, 8'sd46, 8'sd11,
		8'sd37, -8'sd4, 8'sd51, -8'sd29, 8'sd60, -8'sd10, -8'sd48, 8'sd32, // neuron 7
		8'sd7, -8'sd59, 8'sd23, 8'sd42, -8'sd16, 8'sd55, -8'sd25
	};

	localparam bias_t [0:L1_OUT-1] L1_BIASES = {
		16'sd256, -16'sd512, 16'sd0, 16'sd1024,
		-16'sd1280, 16'sd640, -16'sd128, 16'sd384
	};

	// entry [n*L1_OUT + i], hidden outputs are never negative
	localparam weight_t [0:L2_OUT*L1_OUT-1] L2_WEIGHTS = {
		8'sd40, -8'sd35, 8'sd22, 8'sd51, -8'sd18, 8'sd9, -8'sd44, 8'sd30,
		-8'sd27, 8'sd48, -8'sd12, 8'sd19, 8'sd57, -8'sd50, 8'sd14, -8'sd6,
		8'sd15, 8'sd26, -8'sd58, -8'sd9, 8'sd33, 8'sd44, 8'sd21, -8'sd39,
		-8'sd46, -8'sd13, 8'sd37, 8'sd62, -8'sd24, 8'sd8, -8'sd31, 8'sd53
	};

	localparam bias_t [0:L2_OUT-1] L2_BIASES = {
		-16'sd256, 16'sd512, 16'sd128, -16'sd768
	};

endpackage

// File: rtl/neuronNode.sv
`timescale 1ns/100ps

module neuronNode import nnPkg::*; #(
	parameter int NUM_IN = 1,
	parameter weight_t [0:NUM_IN-1] WEIGHTS = '0,
	parameter bias_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input act_t [NUM_IN-1:0] act, // already registered by the layer
	output act_t out
);

	localparam act_t ACT_MAX = 8'sd127;

	product_t prod [NUM_IN];
	accum_t sumNext;
	accum_t sumReg;
	logic roundUp;
	logic [7:0] rounded;

	always_comb
	begin
		for (int i = 0; i < NUM_IN; i++)
		begin
			prod[i] = $signed(act[i]) * $signed(WEIGHTS[i]);
		end
	end

	always_comb
	begin
		sumNext = accum_t'(BIAS);
		for (int i = 0; i < NUM_IN; i++)
		begin
			sumNext = sumNext + accum_t'(prod[i]); // sign-extended products
		end
	end

	// bits 5..0 are the dropped fraction, round half down on an exact tie
	assign roundUp = sumReg[5] && (sumReg[4:0] != 5'd0);
	assign rounded = {1'b0, sumReg[12:6]} + {7'd0, roundUp};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			out <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			if (sumReg[22])
				out <= '0; // rectifier
			else if (sumReg[21:13] != 9'd0 || rounded[7])
				out <= ACT_MAX; // 8192 and up, or rounding carried to 128
			else
				out <= act_t'(rounded);
		end
	end

endmodule

// File: rtl/denseLayer.sv
`timescale 1ns/100ps

module denseLayer import nnPkg::*; #(
	parameter int NUM_IN = 1,
	parameter int NUM_OUT = 1,
	parameter weight_t [0:NUM_OUT*NUM_IN-1] WEIGHTS = '0,
	parameter bias_t [0:NUM_OUT-1] BIASES = '0
) (
	input logic clk,
	input logic reset,
	input act_t [NUM_IN-1:0] inAct,
	input logic inValid,
	output act_t [NUM_OUT-1:0] outAct,
	output logic outValid
);

	act_t [NUM_IN-1:0] actReg; // shared by every neuron
	logic [LAYER_LATENCY-1:0] validPipe;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			validPipe <= '0;
		end
		else
		begin
			if (inValid)
				actReg <= inAct; // hold the vector until the next one arrives
			validPipe <= {validPipe[LAYER_LATENCY-2:0], inValid};
		end
	end

	// lines up with the neurons' output registers
	assign outValid = validPipe[LAYER_LATENCY-1];

	for (genvar n = 0; n < NUM_OUT; n++)
	begin : gNeuron
		neuronNode #(
			.NUM_IN(NUM_IN),
			.WEIGHTS(WEIGHTS[n*NUM_IN +: NUM_IN]),
			.BIAS(BIASES[n])
		) node_i (
			.clk(clk),
			.reset(reset),
			.act(actReg),
			.out(outAct[n])
		);
	end

endmodule

// File: rtl/axiLiteRegs.sv
`timescale 1ns/100ps

module axiLiteRegs import nnPkg::*; #(
	parameter int NUM_IN = L1_IN,
	parameter int NUM_RES = L2_OUT
) (
	input logic clk,
	input logic reset,

	input axiAddr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axiData_t wdata,
	input logic wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input axiAddr_t araddr,
	input logic arvalid,
	output logic arready,
	output axiData_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	output act_t [NUM_IN-1:0] inAct,
	output logic startValid,
	input act_t [NUM_RES-1:0] resAct,
	input logic resValid
);

	localparam int IN_IDX_W = $clog2(NUM_IN);
	localparam int RES_IDX_W = $clog2(NUM_RES);
	localparam int MAX_IN_FLIGHT = 2 * LAYER_LATENCY; // both layers full
	localparam int CNT_W = $clog2(MAX_IN_FLIGHT + 1);
	localparam axiAddr_t IN_SPAN = axiAddr_t'(4 * NUM_IN);
	localparam axiAddr_t RES_SPAN = axiAddr_t'(4 * NUM_RES);

	act_t [NUM_IN-1:0] inReg;
	act_t [NUM_RES-1:0] resReg;
	logic done;
	logic busy;
	logic [CNT_W-1:0] inFlight;

	logic wrEn;
	logic startWr;
	axiAddr_t wrInOff;
	logic wrInHit;

	logic rdEn;
	axiAddr_t rdInOff;
	axiAddr_t rdResOff;
	logic rdInHit;
	logic rdResHit;
	act_t rdInVal;
	act_t rdResVal;
	axiData_t rdWord;

	assign wrEn = awready && awvalid && wvalid;
	assign startWr = wrEn && awaddr == ADDR_CTRL && wdata[0];
	assign wrInOff = awaddr - ADDR_IN_BASE;
	assign wrInHit = wrInOff < IN_SPAN && wrInOff[1:0] == 2'b00;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			// single accept pulse, held off while a response is pending
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready <= awvalid && wvalid && !bvalid && !awready;
			if (wrEn)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	assign bresp = RESP_OKAY;

	always_ff @(posedge clk)
	begin
		if (reset)
			inReg <= '0;
		else if (wrEn && wrInHit)
			inReg[wrInOff[IN_IDX_W+1:2]] <= act_t'(wdata[7:0]); // full-word write
	end

	assign inAct = inReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			startValid <= 1'b0;
			done <= 1'b0;
			inFlight <= '0;
		end
		else
		begin
			startValid <= startWr;
			if (startWr)
				done <= 1'b0; // a fresh start wins over a completion
			else if (resValid)
				done <= 1'b1;
			if (startWr && !resValid)
				inFlight <= inFlight + 1'b1;
			else if (resValid && !startWr)
				inFlight <= inFlight - 1'b1;
		end
	end

	assign busy = inFlight != '0;

	always_ff @(posedge clk)
	begin
		if (reset)
			resReg <= '0;
		else if (resValid)
			resReg <= resAct;
	end

	assign arready = !rvalid;
	assign rdEn = arvalid && arready;
	assign rdInOff = araddr - ADDR_IN_BASE;
	assign rdResOff = araddr - ADDR_RES_BASE;
	assign rdInHit = rdInOff < IN_SPAN && rdInOff[1:0] == 2'b00;
	assign rdResHit = rdResOff < RES_SPAN && rdResOff[1:0] == 2'b00;
	assign rdInVal = inReg[rdInOff[IN_IDX_W+1:2]];
	assign rdResVal = resReg[rdResOff[RES_IDX_W+1:2]];

	always_comb
	begin
		rdWord = '0; // unmapped and control read as zero
		if (rdInHit)
			rdWord = {{24{rdInVal[7]}}, rdInVal}; // sign-extended
		else if (rdResHit)
			rdWord = {24'd0, rdResVal}; // zero-extended
		else if (araddr == ADDR_STATUS)
			rdWord = {30'd0, busy, done};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rvalid <= 1'b0;
			rdata <= '0;
		end
		else if (rdEn)
		begin
			rvalid <= 1'b1;
			rdata <= rdWord; // stays put until rready
		end
		else if (rready)
			rvalid <= 1'b0;
	end

	assign rresp = RESP_OKAY;

endmodule

// File: rtl/mlpAccel.sv
`timescale 1ns/100ps

module mlpAccel import nnPkg::*; (
	input logic clk,
	input logic reset,

	input axiAddr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axiData_t wdata,
	input logic wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input axiAddr_t araddr,
	input logic arvalid,
	output logic arready,
	output axiData_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	act_t [L1_IN-1:0] inAct;
	logic startValid;
	act_t [L1_OUT-1:0] hidAct;
	logic hidValid;
	act_t [L2_OUT-1:0] resAct;
	logic resValid; // startValid plus 2 * LAYER_LATENCY

	axiLiteRegs #(
		.NUM_IN(L1_IN),
		.NUM_RES(L2_OUT)
	) regs_i (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.inAct(inAct),
		.startValid(startValid),
		.resAct(resAct),
		.resValid(resValid)
	);

	denseLayer #(
		.NUM_IN(L1_IN),
		.NUM_OUT(L1_OUT),
		.WEIGHTS(L1_WEIGHTS),
		.BIASES(L1_BIASES)
	) layer1_i (
		.clk(clk),
		.reset(reset),
		.inAct(inAct),
		.inValid(startValid),
		.outAct(hidAct),
		.outValid(hidValid)
	);

	denseLayer #(
		.NUM_IN(L1_OUT),
		.NUM_OUT(L2_OUT),
		.WEIGHTS(L2_WEIGHTS),
		.BIASES(L2_BIASES)
	) layer2_i (
		.clk(clk),
		.reset(reset),
		.inAct(hidAct),
		.inValid(hidValid),
		.outAct(resAct),
		.outValid(resValid)
	);

endmodule

// File: testbench/mlpAccel_asserts.sv
`timescale 1ns/100ps

module mlpAccel_asserts import nnPkg::*; (
	input logic clk,
	input logic reset,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input axiData_t rdata,
	input logic startValid,
	input logic resValid
);

	localparam int PIPE_DEPTH = 2 * LAYER_LATENCY; // two layers back to back

	bHold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	rHold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	rDataStable: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while the read response waited");

	resOnTime: assert property (@(posedge clk) disable iff (reset)
		$past(startValid, PIPE_DEPTH) |-> resValid)
		else $error("no result %0d cycles after a start", PIPE_DEPTH);

	resNotEarly: assert property (@(posedge clk) disable iff (reset)
		resValid |-> $past(startValid, PIPE_DEPTH))
		else $error("result without a start %0d cycles before", PIPE_DEPTH);

endmodule

bind axiLiteRegs mlpAccel_asserts asserts_i (
	.clk(clk),
	.reset(reset),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.startValid(startValid),
	.resValid(resValid)
);

// File: testbench/mlpAccel_tb.sv
`timescale 1ns/100ps

module mlpAccel_tb import nnPkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int TXN_BUDGET = 1200; // rough count of AXI transactions in all tests
	localparam int CYCLES_PER_TXN = 200;
	localparam int POLL_LIMIT = 50;
	localparam axiData_t STATUS_DONE = 32'h1;
	localparam axiData_t STATUS_BUSY = 32'h2;

	typedef act_t [L1_IN-1:0] inVec_t;
	typedef act_t [L2_OUT-1:0] resVec_t;

	logic clk;
	logic reset;
	axiAddr_t awaddr;
	logic awvalid;
	logic awready;
	axiData_t wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	axiAddr_t araddr;
	logic arvalid;
	logic arready;
	axiData_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [15:0] lfsrState;

	mlpAccel mlpAccel_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TXN_BUDGET * CYCLES_PER_TXN * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles",
			TXN_BUDGET * CYCLES_PER_TXN);
		stopWithFailure();
	end

	task automatic stopWithFailure();
		$display("Verification failed");
		$fatal(1, "stopping the run");
	endtask

	task automatic abortRun(input string why);
		$display("at %0t ns: %s", $time, why);
		stopWithFailure();
	endtask

	task automatic checkData(input axiData_t got, input axiData_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s, read %h, expected %h", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkResp(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s, response %b, expected %b", $time, what, got, exp);
			stopWithFailure();
		end
	endtask

	// galois form, taps 16 14 13 11
	function automatic logic lfsrBit();
		logic lsb;
		lsb = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (lsb)
			lfsrState = lfsrState ^ 16'hB400;
		return lsb;
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsrBit()};
		return v;
	endfunction

	function automatic int pickDelay(input bit jitter);
		return jitter ? randBits(2) : 0;
	endfunction

	function automatic act_t neuronRef(input int acc);
		int q;
		if (acc < 0)
			return 8'sd0;
		if (acc >= 8192)
			return 8'sd127;
		q = acc / 64;
		if (acc % 64 > 32)
			q++; // more than half an lsb rounds up
		if (q > 127)
			q = 127;
		return act_t'(q);
	endfunction

	function automatic resVec_t modelMlp(input inVec_t vec);
		act_t [L1_OUT-1:0] hid;
		resVec_t res;
		int acc;
		for (int n = 0; n < L1_OUT; n++)
		begin
			acc = int'(L1_BIASES[n]);
			for (int i = 0; i < L1_IN; i++)
				acc += int'(vec[i]) * int'(L1_WEIGHTS[n * L1_IN + i]);
			hid[n] = neuronRef(acc);
		end
		for (int n = 0; n < L2_OUT; n++)
		begin
			acc = int'(L2_BIASES[n]);
			for (int i = 0; i < L1_OUT; i++)
				acc += int'(hid[i]) * int'(L2_WEIGHTS[n * L1_OUT + i]);
			res[n] = neuronRef(acc);
		end
		return res;
	endfunction

	// every AXI task starts and ends just after a falling edge
	task automatic axiWrite(input axiAddr_t addr, input axiData_t data, input int bDelay);
		logic [1:0] resp;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do
			@(negedge clk);
		while (!(awready && wready));
		@(negedge clk); // accepted on the edge just passed
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (bDelay) @(negedge clk);
		if (!bvalid)
			abortRun("write response did not stay valid until bready");
		resp = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
		checkResp(resp, RESP_OKAY, "write response");
	endtask

	task automatic axiRead(input axiAddr_t addr, input int rDelay,
		output axiData_t data, output logic [1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready)
			@(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		repeat (rDelay) @(negedge clk);
		if (!rvalid)
			abortRun("read data did not stay valid until rready");
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 0;
	endtask

	task automatic readCheck(input axiAddr_t addr, input axiData_t exp, input bit jitter,
		input string what);
		axiData_t data;
		logic [1:0] resp;
		axiRead(addr, pickDelay(jitter), data, resp);
		checkResp(resp, RESP_OKAY, what);
		checkData(data, exp, what);
	endtask

	task automatic loadVector(input inVec_t vec, input bit jitter);
		for (int i = 0; i < L1_IN; i++)
			axiWrite(axiAddr_t'(ADDR_IN_BASE + 4 * i), {24'h5A5A5A, vec[i]}, pickDelay(jitter));
	endtask

	task automatic startInference(input bit jitter);
		axiWrite(ADDR_CTRL, 32'h1, pickDelay(jitter));
	endtask

	task automatic waitDone(input bit jitter);
		axiData_t status;
		logic [1:0] resp;
		int polls;
		polls = 0;
		do
		begin
			if (polls == POLL_LIMIT)
				abortRun("status never showed done with busy clear");
			axiRead(ADDR_STATUS, pickDelay(jitter), status, resp);
			checkResp(resp, RESP_OKAY, "status poll");
			polls++;
		end
		while (status != STATUS_DONE);
	endtask

	task automatic checkResults(input inVec_t vec, input bit jitter);
		resVec_t exp;
		exp = modelMlp(vec);
		for (int n = 0; n < L2_OUT; n++)
			readCheck(axiAddr_t'(ADDR_RES_BASE + 4 * n), {24'd0, exp[n]}, jitter,
				$sformatf("result %0d", n));
	endtask

	task automatic testResetAndMap();
		axiAddr_t holes [5];
		act_t v;
		holes = '{8'h3C, 8'h41, 8'h48, 8'h90, 8'hFC};
		readCheck(ADDR_STATUS, 32'h0, 1'b0, "status after reset");
		for (int n = 0; n < L2_OUT; n++)
			readCheck(axiAddr_t'(ADDR_RES_BASE + 4 * n), 32'h0, 1'b0, "result after reset");
		for (int i = 0; i < L1_IN; i++)
		begin
			v = act_t'(8'(i * 29 + 140));
			axiWrite(axiAddr_t'(ADDR_IN_BASE + 4 * i), {24'hC3C3C3, v}, 1);
			readCheck(axiAddr_t'(ADDR_IN_BASE + 4 * i), axiData_t'(int'(v)), 1'b0,
				$sformatf("input %0d read back", i));
		end
		foreach (holes[k])
			axiWrite(holes[k], 32'hFFFF_FFFF, 0); // all ones, none of it may land
		readCheck(ADDR_STATUS, 32'h0, 1'b0, "status after unmapped writes");
		readCheck(axiAddr_t'(ADDR_IN_BASE + 4 * (L1_IN - 1)), axiData_t'(int'(v)), 1'b0,
			"last input after unmapped writes");
		foreach (holes[k])
			readCheck(holes[k], 32'h0, 1'b0, $sformatf("unmapped address %h", holes[k]));
	endtask

	task automatic testFixedVector();
		inVec_t vec;
		for (int i = 0; i < L1_IN; i++)
			vec[i] = act_t'(8'(i * 23 + 5));
		loadVector(vec, 1'b0);
		startInference(1'b0);
		waitDone(1'b0);
		checkResults(vec, 1'b0);
	endtask

	task automatic testRandomVectors();
		inVec_t vec;
		resVec_t exp;
		int zeros;
		int saturated;
		zeros = 0;
		saturated = 0;
		for (int v = 0; v < 40; v++)
		begin
			for (int i = 0; i < L1_IN; i++)
			begin
				vec[i] = act_t'(8'(randBits(8)));
				if (v % 3 == 1)
					vec[i] = vec[i] >>> 2; // smaller inputs land between the rails
			end
			exp = modelMlp(vec);
			for (int n = 0; n < L2_OUT; n++)
			begin
				zeros += int'(exp[n] == 8'sd0);
				saturated += int'(exp[n] == 8'sd127);
			end
			loadVector(vec, 1'b1);
			startInference(1'b1);
			waitDone(1'b1);
			checkResults(vec, 1'b1);
		end
		if (zeros == 0 || saturated == 0)
			abortRun("random vectors did not reach both a zero and a saturated result");
	endtask

	task automatic testStatusFlags();
		startInference(1'b0);
		readCheck(ADDR_STATUS, STATUS_BUSY, 1'b0, "status right after start");
		waitDone(1'b0);
		readCheck(ADDR_STATUS, STATUS_DONE, 1'b0, "status after completion");
		startInference(1'b0);
		readCheck(ADDR_STATUS, STATUS_BUSY, 1'b0, "status after a second start");
		waitDone(1'b0);
	endtask

	task automatic testBackToBack();
		inVec_t vec;
		for (int i = 0; i < L1_IN; i++)
			vec[i] = act_t'(8'(randBits(8)));
		loadVector(vec, 1'b0);
		startInference(1'b0);
		vec[3] = -8'sd77;
		axiWrite(axiAddr_t'(ADDR_IN_BASE + 12), {24'd0, vec[3]}, 0);
		startInference(1'b0);
		vec[7] = 8'sd101;
		axiWrite(axiAddr_t'(ADDR_IN_BASE + 28), {24'd0, vec[7]}, 0);
		startInference(1'b0); // the second inference is still in flight
		waitDone(1'b0);
		checkResults(vec, 1'b0);
		readCheck(ADDR_STATUS, STATUS_DONE, 1'b0, "status after back-to-back starts");
	endtask

	initial
	begin
		lfsrState = 16'd9838;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		testResetAndMap();
		testFixedVector();
		testRandomVectors();
		testStatusFlags();
		testBackToBack();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: tb.f
rtl/nnPkg.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/axiLiteRegs.sv
rtl/mlpAccel.sv
testbench/mlpAccel_asserts.sv
testbench/mlpAccel_tb.sv

// File: Makefile
# Verilator build and run of the mlpAccel testbench

VERILATOR ?= verilator
FILELIST ?= tb.f
TOP ?= mlpAccel_tb
RTL_TOP ?= mlpAccel
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
